/* src/eeprom_pkg.sv */
package eeprom_pkg;

    // 24C16 geometry
    localparam int addr_w = 11;
    localparam int data_w = 8;

    // device type code in the top nibble of every control byte
    localparam logic [3:0] ctrl_code = 4'b1010;

    // CLK cycles per quarter SCL period
    localparam int quarter_cycles = 1;

    // one operation for the bit engine
    typedef enum logic [1:0] {
        op_start,
        op_stop,
        op_tx_byte,
        op_rx_byte
    } ee_bus_op_e;

    // latched host request
    typedef struct packed {
        logic              is_read;
        logic [addr_w-1:0] addr;
        logic [data_w-1:0] wdata;
    } ee_req_t;

    typedef struct packed {
        ee_bus_op_e        op;
        logic [data_w-1:0] tx_byte;
        logic              master_ack; // low: no ack after a received byte
    } ee_bus_cmd_t;

    // end of transaction
    typedef struct packed {
        logic [data_w-1:0] rdata;
        logic              nack;
    } ee_result_t;

endpackage

/* src/eeprom_cmd_regs.sv */
`timescale 1ns/100ps

module eeprom_cmd_regs (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::addr_w-1:0] addr,
    input  logic [eeprom_pkg::data_w-1:0] wdata,
    output logic                          go,
    output eeprom_pkg::ee_req_t           req,
    input  logic                          finish,
    input  eeprom_pkg::ee_result_t        result,
    output logic                          busy,
    output logic                          done,
    output logic                          nack,
    output logic [eeprom_pkg::data_w-1:0] rdata
);
    import eeprom_pkg::*;

    logic       accept;
    ee_result_t res_q;   // held until the next done

    // strobes during a transaction are dropped
    assign accept = !busy && (wr || rd);

    assign rdata = res_q.rdata;
    assign nack  = res_q.nack;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            go    <= 1'b0;
            busy  <= 1'b0;
            done  <= 1'b0;
            res_q <= '0;
        end
        else
        begin
            go   <= accept;
            done <= finish;   // one cycle after finish

            if (accept)
                busy <= 1'b1;
            else if (finish)
                busy <= 1'b0;

            if (finish)
                res_q <= result;
        end
    end

    // request fields, write wins over read
    always_ff @(posedge CLK)
    begin
        if (accept)
        begin
            req.is_read <= !wr;
            req.addr    <= addr;
            req.wdata   <= wdata;
        end
    end

endmodule

/* src/eeprom_sequencer.sv */
`timescale 1ns/100ps

module eeprom_sequencer (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          go,
    input  eeprom_pkg::ee_req_t           req,
    output logic                          finish,
    output eeprom_pkg::ee_result_t        result,
    output logic                          op_go,
    output eeprom_pkg::ee_bus_cmd_t       bus_cmd,
    input  logic                          op_done,
    input  logic [eeprom_pkg::data_w-1:0] rx_byte,
    input  logic                          ack_seen
);
    import eeprom_pkg::*;

    typedef enum logic [3:0] {
        s_idle,
        s_start,
        s_ctrl_w,
        s_addr,
        s_data,
        s_rstart,
        s_ctrl_r,
        s_read,
        s_stop
    } seq_state_e;

    seq_state_e        st;
    seq_state_e        nxt_st;
    logic              issue;       // launch nxt_cmd next cycle
    ee_bus_cmd_t       nxt_cmd;
    logic              flag_nack;
    logic              fin_nxt;
    logic              tx_state;
    logic [data_w-1:0] ctrl_wr;
    logic [data_w-1:0] ctrl_rd;

    function automatic ee_bus_cmd_t mk_cmd(ee_bus_op_e op, logic [data_w-1:0] b, logic ack);
        ee_bus_cmd_t c;
        c.op         = op;
        c.tx_byte    = b;
        c.master_ack = ack;
        return c;
    endfunction

    // block select travels in the control byte
    assign ctrl_wr = {ctrl_code, req.addr[addr_w-1:8], 1'b0};
    assign ctrl_rd = {ctrl_code, req.addr[addr_w-1:8], 1'b1};

    // states whose op was a transmitted byte
    assign tx_state = (st == s_ctrl_w) || (st == s_addr) || (st == s_data) || (st == s_ctrl_r);

    always_comb
    begin
        nxt_st    = st;
        issue     = 1'b0;
        nxt_cmd   = mk_cmd(op_stop, '0, 1'b0);
        flag_nack = 1'b0;
        fin_nxt   = 1'b0;

        if (op_done && tx_state && !ack_seen)
        begin
            // no slave ack, straight to stop
            flag_nack = 1'b1;
            issue     = 1'b1;
            nxt_st    = s_stop;
        end
        else if (st == s_idle)
        begin
            if (go)
            begin
                issue   = 1'b1;
                nxt_cmd = mk_cmd(op_start, '0, 1'b0);
                nxt_st  = s_start;
            end
        end
        else if (op_done)
        begin
            issue = 1'b1;
            case (st)
                s_start:  begin nxt_cmd = mk_cmd(op_tx_byte, ctrl_wr, 1'b0); nxt_st = s_ctrl_w; end
                s_ctrl_w: begin nxt_cmd = mk_cmd(op_tx_byte, req.addr[7:0], 1'b0); nxt_st = s_addr; end
                s_addr:
                begin
                    if (req.is_read)
                    begin
                        nxt_cmd = mk_cmd(op_start, '0, 1'b0);   // repeated start
                        nxt_st  = s_rstart;
                    end
                    else
                    begin
                        nxt_cmd = mk_cmd(op_tx_byte, req.wdata, 1'b0);
                        nxt_st  = s_data;
                    end
                end
                s_rstart: begin nxt_cmd = mk_cmd(op_tx_byte, ctrl_rd, 1'b0); nxt_st = s_ctrl_r; end
                s_ctrl_r: begin nxt_cmd = mk_cmd(op_rx_byte, '0, 1'b0); nxt_st = s_read; end
                s_stop:
                begin
                    issue   = 1'b0;
                    fin_nxt = 1'b1;
                    nxt_st  = s_idle;
                end
                default:  nxt_st = s_stop;   // data or read byte done
            endcase
        end
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            st     <= s_idle;
            op_go  <= 1'b0;
            finish <= 1'b0;
        end
        else
        begin
            st     <= nxt_st;
            op_go  <= issue;
            finish <= fin_nxt;
        end
    end

    always_ff @(posedge CLK)
    begin
        if (issue)
            bus_cmd <= nxt_cmd;

        if (st == s_idle && go)
            result <= '0;   // writes report rdata 0
        else if (flag_nack)
            result.nack <= 1'b1;
        else if (st == s_read && op_done)
            result.rdata <= rx_byte;
    end

endmodule

/* src/eeprom_bit_engine.sv */
`timescale 1ns/100ps

module eeprom_bit_engine (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          op_go,
    input  eeprom_pkg::ee_bus_cmd_t       bus_cmd,
    output logic                          op_done,
    output logic [eeprom_pkg::data_w-1:0] rx_byte,
    output logic                          ack_seen,
    output logic                          scl,
    output logic                          sda_low,
    input  logic                          sda_in
);
    import eeprom_pkg::*;

    localparam int tick_w = (quarter_cycles > 1) ? $clog2(quarter_cycles) : 1;

    ee_bus_cmd_t       cmd;        // operation in flight
    logic              active;
    logic [tick_w-1:0] tick_cnt;
    logic [1:0]        phase;      // quarter within the current bit
    logic [3:0]        bit_cnt;    // 0..8, ack slot is 8
    logic [data_w-1:0] shreg;
    logic              tick;
    logic              is_byte;
    logic              last_bit;
    logic              last_q;
    logic              sample;

    // data slot level of a byte frame
    function automatic logic frame_sda_low(ee_bus_cmd_t c, logic [3:0] b, logic msb);
        if (b == 4'd8)
            return (c.op == op_rx_byte) && c.master_ack;
        return (c.op == op_tx_byte) && !msb;
    endfunction

    assign tick     = (tick_cnt == tick_w'(quarter_cycles - 1));
    assign is_byte  = (cmd.op == op_tx_byte) || (cmd.op == op_rx_byte);
    assign last_bit = !is_byte || (bit_cnt == 4'd8);
    assign last_q   = (phase == 2'd3) && last_bit;
    assign sample   = active && tick && is_byte && (phase == 2'd1);   // mid SCL high
    assign rx_byte  = shreg;

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            active   <= 1'b0;
            op_done  <= 1'b0;
            tick_cnt <= '0;
            phase    <= 2'd0;
            bit_cnt  <= 4'd0;
            scl      <= 1'b1;   // idle bus
            sda_low  <= 1'b0;
        end
        else
        begin
            op_done <= 1'b0;
            if (op_go && !active)
            begin
                active   <= 1'b1;
                tick_cnt <= '0;
                phase    <= 2'd0;
                bit_cnt  <= 4'd0;
                scl      <= 1'b0;   // every op opens with scl low
                case (bus_cmd.op)
                    op_start: sda_low <= 1'b0;
                    op_stop:  sda_low <= 1'b1;
                    default:  sda_low <= frame_sda_low(bus_cmd, 4'd0, bus_cmd.tx_byte[7]);
                endcase
            end
            else if (active && !tick)
                tick_cnt <= tick_cnt + 1'b1;
            else if (active)
            begin
                tick_cnt <= '0;
                if (last_q)
                begin
                    active  <= 1'b0;
                    op_done <= 1'b1;
                end
                else if (phase == 2'd3)
                begin
                    // next bit, sda moves only here while scl is low
                    phase   <= 2'd0;
                    bit_cnt <= bit_cnt + 4'd1;
                    scl     <= 1'b0;
                    sda_low <= frame_sda_low(cmd, bit_cnt + 4'd1, shreg[7]);
                end
                else
                begin
                    phase <= phase + 2'd1;
                    scl   <= (phase != 2'd2) || (cmd.op == op_stop);
                    case (cmd.op)
                        op_start: sda_low <= (phase != 2'd0);   // falls with scl high
                        op_stop:  sda_low <= (phase == 2'd0);   // rises with scl high
                        default:  sda_low <= sda_low;
                    endcase
                end
            end
        end
    end

    always_ff @(posedge CLK)
    begin
        if (op_go && !active)
        begin
            cmd   <= bus_cmd;
            shreg <= bus_cmd.tx_byte;
        end
        else if (sample)
        begin
            if (bit_cnt == 4'd8)
                ack_seen <= !sda_in;   // slave pulled low
            else
                shreg <= {shreg[data_w-2:0], sda_in};
        end
    end

endmodule

/* src/eeprom_ctrl_top.sv */
`timescale 1ns/100ps

module eeprom_ctrl_top (
    input  logic                          CLK,
    input  logic                          RESET,
    input  logic                          wr,
    input  logic                          rd,
    input  logic [eeprom_pkg::addr_w-1:0] addr,
    input  logic [eeprom_pkg::data_w-1:0] wdata,
    output logic                          busy,
    output logic                          done,
    output logic                          nack,
    output logic [eeprom_pkg::data_w-1:0] rdata,
    output logic                          scl,
    inout  wire                           sda
);
    import eeprom_pkg::*;

    logic              go;
    ee_req_t           req;
    logic              finish;
    ee_result_t        result;
    logic              op_go;
    ee_bus_cmd_t       bus_cmd;
    logic              op_done;
    logic [data_w-1:0] rx_byte;
    logic              ack_seen;
    logic              sda_low;
    logic              sda_in;

    // open drain, pull-up is external
    assign sda    = sda_low ? 1'b0 : 1'bz;
    assign sda_in = sda;

    eeprom_cmd_regs cmd_regs_inst (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .go(go), .req(req), .finish(finish), .result(result),
        .busy(busy), .done(done), .nack(nack), .rdata(rdata)
    );

    eeprom_sequencer sequencer_inst (
        .CLK(CLK), .RESET(RESET), .go(go), .req(req), .finish(finish), .result(result),
        .op_go(op_go), .bus_cmd(bus_cmd), .op_done(op_done), .rx_byte(rx_byte),
        .ack_seen(ack_seen)
    );

    eeprom_bit_engine bit_engine_inst (
        .CLK(CLK), .RESET(RESET), .op_go(op_go), .bus_cmd(bus_cmd), .op_done(op_done),
        .rx_byte(rx_byte), .ack_seen(ack_seen), .scl(scl), .sda_low(sda_low), .sda_in(sda_in)
    );

endmodule

/* testbench/tb_clock.sv */
`timescale 1ns/100ps

module tb_clock (
    output logic CLK
);
    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;   // 100 ns period
    end

endmodule

/* testbench/eeprom_model.sv */
`timescale 1ns/100ps

module eeprom_model (
    input  logic CLK,
    input  logic scl,
    inout  wire  sda,
    input  logic nack_en   // withhold the control byte ack
);
    logic [7:0]  mem [0:2047];
    logic        scl_q;
    logic        sda_q;
    logic        sda_v;
    logic        drive_low;
    logic [3:0]  bit_cnt;
    logic [1:0]  byte_idx;
    logic [7:0]  shreg;
    logic [7:0]  out_byte;
    logic [2:0]  blk;
    logic [10:0] ptr;
    logic        listen;
    logic        sending;
    logic        to_send;

    assign sda   = drive_low ? 1'b0 : 1'bz;
    assign sda_v = (sda === 1'b0) ? 1'b0 : 1'b1;

    initial
    begin
        for (int i = 0; i < 2048; i++)
            mem[i] = 8'(i) ^ 8'(i >> 3) ^ 8'h5a;
        scl_q     = 1'b1;
        sda_q     = 1'b1;
        drive_low = 1'b0;
        bit_cnt   = 4'd0;
        byte_idx  = 2'd0;
        listen    = 1'b0;
        sending   = 1'b0;
        to_send   = 1'b0;
    end

    always @(posedge CLK)
    begin
        scl_q <= scl;
        sda_q <= sda_v;
        if (scl && scl_q && sda_q && !sda_v)
        begin
            // start or repeated start
            listen    <= 1'b1;
            sending   <= 1'b0;
            to_send   <= 1'b0;
            bit_cnt   <= 4'd0;
            byte_idx  <= 2'd0;
            drive_low <= 1'b0;
        end
        else if (scl && scl_q && !sda_q && sda_v)
        begin
            listen    <= 1'b0;   // stop
            sending   <= 1'b0;
            drive_low <= 1'b0;
        end
        else if (scl && !scl_q && (listen || sending))
        begin
            if (listen && bit_cnt < 4'd8)
                shreg <= {shreg[6:0], sda_v};
            bit_cnt <= bit_cnt + 4'd1;
        end
        else if (!scl && scl_q && (listen || sending))
        begin
            if (bit_cnt == 4'd8 && listen)
            begin
                byte_idx <= byte_idx + 2'd1;
                case (byte_idx)
                    2'd0:
                    begin
                        if (shreg[7:4] == 4'b1010 && !nack_en)
                        begin
                            drive_low <= 1'b1;
                            blk       <= shreg[3:1];
                            to_send   <= shreg[0];
                        end
                        else
                            listen <= 1'b0;   // not addressed
                    end
                    2'd1:
                    begin
                        ptr       <= {blk, shreg};
                        drive_low <= 1'b1;
                    end
                    2'd2:
                    begin
                        mem[ptr]  <= shreg;
                        drive_low <= 1'b1;
                    end
                    default: drive_low <= 1'b1;
                endcase
            end
            else if (bit_cnt == 4'd8)
                drive_low <= 1'b0;   // master ack slot
            else if (bit_cnt == 4'd9)
            begin
                bit_cnt   <= 4'd0;
                drive_low <= 1'b0;
                if (to_send)
                begin
                    listen    <= 1'b0;
                    sending   <= 1'b1;
                    to_send   <= 1'b0;
                    out_byte  <= mem[ptr];
                    drive_low <= !mem[ptr][7];
                end
                else if (sending)
                    sending <= 1'b0;   // single byte reads only
            end
            else if (sending)
                drive_low <= !out_byte[3'd7 - bit_cnt[2:0]];
        end
    end

endmodule

/* testbench/eeprom_ctrl_sva.sv */
`timescale 1ns/100ps

module eeprom_ctrl_sva (
    input logic       CLK,
    input logic       RESET,
    input logic       scl,
    input logic       sda_low,
    input logic       op_go,
    input logic       op_done,
    input logic [1:0] op
);
    import eeprom_pkg::*;

    logic pending;   // an op is in flight
    logic started;   // some op issued since reset

    always_ff @(posedge CLK)
    begin
        if (RESET)
            pending <= 1'b0;
        else if (op_go)
            pending <= 1'b1;
        else if (op_done)
            pending <= 1'b0;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
            started <= 1'b0;
        else if (op_go)
            started <= 1'b1;
    end

    sda_stable_scl_high: assert property (@(posedge CLK) disable iff (RESET)
        (scl && $past(scl) && (sda_low != $past(sda_low)))
            |-> (op == op_start || op == op_stop))
        else $error("sda moved while scl high outside start or stop");

    done_after_go: assert property (@(posedge CLK) disable iff (RESET)
        op_done |-> pending)
        else $error("op_done without op_go");

    // bus stays idle until the first op
    idle_after_reset: assert property (@(posedge CLK) disable iff (RESET)
        !started |-> (scl && !sda_low))
        else $error("bus not idle after reset");

endmodule

bind eeprom_bit_engine eeprom_ctrl_sva sva_inst (
    .CLK(CLK), .RESET(RESET), .scl(scl), .sda_low(sda_low),
    .op_go(op_go), .op_done(op_done), .op(cmd.op)
);

/* testbench/tb_eeprom_ctrl.sv */
`timescale 1ns/100ps

module tb_eeprom_ctrl;
    logic        CLK;
    logic        RESET;
    logic        wr;
    logic        rd;
    logic [10:0] addr;
    logic [7:0]  wdata;
    logic        busy;
    logic        done;
    logic        nack;
    logic [7:0]  rdata;
    logic        scl;
    logic        nack_en;
    wire         sda;

    int          errors = 0;
    int          checks = 0;
    int          cycles = 0;
    int          limit  = 1000000;
    logic [31:0] rng    = 32'h3a42;
    logic [7:0]  exp_mem [0:2047];
    logic [10:0] rand_addr [$];

    pullup (sda);

    tb_clock clock_inst (.CLK(CLK));

    eeprom_ctrl_top eeprom_ctrl_top_inst (
        .CLK(CLK), .RESET(RESET), .wr(wr), .rd(rd), .addr(addr), .wdata(wdata),
        .busy(busy), .done(done), .nack(nack), .rdata(rdata), .scl(scl), .sda(sda)
    );

    eeprom_model model_inst (.CLK(CLK), .scl(scl), .sda(sda), .nack_en(nack_en));

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic strobe(input logic is_read, input logic [10:0] a, input logic [7:0] d);
        @(negedge CLK);
        wr    = !is_read;
        rd    = is_read;
        addr  = a;
        wdata = d;
        @(negedge CLK);
        wr = 1'b0;
        rd = 1'b0;
    endtask

    task automatic wait_done;
        while (!done)
            @(negedge CLK);
    endtask

    task automatic run_op(input logic is_read, input logic [10:0] a, input logic [7:0] d,
                          input logic [7:0] exp_rd, input logic exp_nack);
        strobe(is_read, a, d);
        wait_done();
        check("rdata", rdata, exp_rd);
        check("nack", nack, exp_nack);
        if (!is_read && !exp_nack)
            exp_mem[a] = d;
    endtask

    // hang guard
    always @(posedge CLK)
    begin
        cycles++;
        if (cycles > limit)
        begin
            $display("timeout: the run hung after %0d cycles", cycles);
            $display("sim failed");
            $finish;
        end
    end

    initial
    begin
        int          fd;
        int          n_ops;
        int          extra_done;
        string       line;
        logic [7:0]  kind;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_rdata;
        logic [31:0] f_nack;
        logic [31:0] f_mnack;
        logic [7:0]  kinds [$];
        logic [31:0] fields [$];

        wr      = 1'b0;
        rd      = 1'b0;
        addr    = '0;
        wdata   = '0;
        nack_en = 1'b0;
        RESET   = 1'b1;

        fd = $fopen("testbench/eeprom_stim.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the stimulus file");
            errors++;
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                if (line.len() > 1 && line[0] != "#")
                begin
                    void'($sscanf(line, "%c %h %h %h %h %h", kind, f_addr, f_wdata,
                                  f_rdata, f_nack, f_mnack));
                    kinds.push_back(kind);
                    fields.push_back(f_addr);
                    fields.push_back(f_wdata);
                    fields.push_back(f_rdata);
                    fields.push_back(f_nack);
                    fields.push_back(f_mnack);
                end
            end
            $fclose(fd);
        end

        // stim ops, busy test, 12 random writes and reads, settle time
        n_ops = kinds.size() + 2 + 24;
        limit = n_ops * 250 + 100 + 300;

        repeat (3) @(negedge CLK);
        RESET = 1'b0;
        @(negedge CLK);
        check("busy", busy, 1'b0);
        check("done", done, 1'b0);
        check("scl", scl, 1'b1);

        for (int i = 0; i < kinds.size(); i++)
        begin
            nack_en = fields[i*5+4][0];
            run_op(kinds[i] == "R", fields[i*5][10:0], fields[i*5+1][7:0],
                   fields[i*5+2][7:0], fields[i*5+3][0]);
            nack_en = 1'b0;
        end

        // second strobe while busy must be dropped
        @(negedge CLK);
        wr    = 1'b1;
        addr  = 11'h400;
        wdata = 8'haa;
        @(negedge CLK);
        check("busy", busy, 1'b1);
        wdata = 8'h55;
        @(negedge CLK);
        wr = 1'b0;
        wait_done();
        exp_mem[11'h400] = 8'haa;
        extra_done = 0;
        repeat (300)
        begin
            @(negedge CLK);
            if (done)
                extra_done++;
        end
        check("extra_done", extra_done, 0);
        run_op(1'b1, 11'h400, 8'h00, exp_mem[11'h400], 1'b0);

        for (int i = 0; i < 12; i++)
        begin
            rng = xorshift32(rng);
            rand_addr.push_back(rng[10:0]);
            run_op(1'b0, rng[10:0], rng[23:16], 8'h00, 1'b0);
        end
        foreach (rand_addr[i])
            run_op(1'b1, rand_addr[i], 8'h00, exp_mem[rand_addr[i]], 1'b0);

        $display("checks: %0d errors: %0d", checks, errors);
        if (errors == 0)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

/* eeprom_ctrl.f */
src/eeprom_pkg.sv
src/eeprom_cmd_regs.sv
src/eeprom_sequencer.sv
src/eeprom_bit_engine.sv
src/eeprom_ctrl_top.sv
testbench/tb_clock.sv
testbench/eeprom_model.sv
testbench/eeprom_ctrl_sva.sv
testbench/tb_eeprom_ctrl.sv

/* run_sim.sh */
#!/bin/sh
# build and run the EEPROM controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert \
    -f eeprom_ctrl.f \
    --top-module tb_eeprom_ctrl \
    -Mdir obj_dir

./obj_dir/Vtb_eeprom_ctrl | tee sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
exit 0

/* testbench/eeprom_stim.txt */
# kind addr(hex) wdata(hex) exp_rdata(hex) exp_nack model_nack
# writes report rdata 00
W 055 3c 00 0 0
R 055 00 3c 0 0
W 123 11 00 0 0
W 223 22 00 0 0
W 723 77 00 0 0
W 023 a0 00 0 0
R 123 00 11 0 0
R 223 00 22 0 0
R 723 00 77 0 0
R 023 00 a0 0 0
R 055 00 00 1 1
R 055 00 3c 0 0
W 300 ee 00 1 1
W 301 c3 00 0 0
R 301 00 c3 0 0
R 023 00 a0 0 0
